// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_fetch_decode
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ns -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@grep -qx "Test OK" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/fetch_decode.sv
`timescale 1ns/1ns

module fetch_decode (
	input  logic clk,
	input  logic rst,
	input  logic warp_start,
	input  warp_pkg::warp_id_t start_warp,
	input  warp_pkg::pc_t start_pc,
	output warp_pkg::pc_t imem_addr,
	input  isa_pkg::inst_t imem_data,
	output logic dec_valid,
	input  logic dec_ready,
	output warp_pkg::warp_id_t dec_warp,
	output warp_pkg::pc_t dec_pc,
	output isa_pkg::opcode_t dec_opcode,
	output isa_pkg::reg_idx_t dec_dst,
	output isa_pkg::reg_idx_t dec_src1,
	output isa_pkg::reg_idx_t dec_src2,
	output isa_pkg::imm_t dec_imm,
	output logic dec_reg_write,
	output logic dec_mem_read,
	output logic dec_mem_write,
	output logic dec_src1_valid,
	output logic dec_src2_valid,
	output logic dec_imm_valid,
	output logic dec_jmp,
	output logic dec_beq,
	output logic dec_blt,
	output logic dec_exit
);

	fetch_if fetch_q();     // scheduler to queue
	fetch_if q_dec();       // queue to decoder
	pc_update_if pc_upd();  // decoder back to scheduler

	warp_fetch i_warp_fetch (
		.clk(clk),
		.rst(rst),
		.warp_start(warp_start),
		.start_warp(start_warp),
		.start_pc(start_pc),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.fetch(fetch_q),
		.upd(pc_upd)
	);

	fetch_queue i_fetch_queue (
		.clk(clk),
		.rst(rst),
		.in(fetch_q),
		.out(q_dec)
	);

	inst_decode i_inst_decode (
		.clk(clk),
		.rst(rst),
		.in(q_dec),
		.upd(pc_upd),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec_warp(dec_warp),
		.dec_pc(dec_pc),
		.dec_opcode(dec_opcode),
		.dec_dst(dec_dst),
		.dec_src1(dec_src1),
		.dec_src2(dec_src2),
		.dec_imm(dec_imm),
		.dec_reg_write(dec_reg_write),
		.dec_mem_read(dec_mem_read),
		.dec_mem_write(dec_mem_write),
		.dec_src1_valid(dec_src1_valid),
		.dec_src2_valid(dec_src2_valid),
		.dec_imm_valid(dec_imm_valid),
		.dec_jmp(dec_jmp),
		.dec_beq(dec_beq),
		.dec_blt(dec_blt),
		.dec_exit(dec_exit)
	);

endmodule

// File: hdl/fetch_if.sv
`timescale 1ns/1ns

// One fetched instruction tagged with its warp and PC
interface fetch_if;
	logic valid;
	logic ready;
	warp_pkg::warp_id_t warp;
	warp_pkg::pc_t pc;
	isa_pkg::inst_t inst;

	modport src (output valid, output warp, output pc, output inst, input ready);
	modport dst (input valid, input warp, input pc, input inst, output ready);
endinterface

// Decoder tells the scheduler where a warp goes next
interface pc_update_if;
	logic valid;  // single-cycle pulse, always taken
	warp_pkg::warp_id_t warp;
	warp_pkg::pc_t next_pc;
	logic keep_active;  // low on EXIT

	modport src (output valid, output warp, output next_pc, output keep_active);
	modport dst (input valid, input warp, input next_pc, input keep_active);
endinterface

// File: hdl/fetch_queue.sv
`timescale 1ns/1ns

`include "front_params.svh"

module fetch_queue (
	input  logic clk,
	input  logic rst,
	fetch_if.dst in,
	fetch_if.src out
);

	localparam int DEPTH = `FQ_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	warp_pkg::warp_id_t mem_warp [DEPTH];
	warp_pkg::pc_t mem_pc [DEPTH];
	isa_pkg::inst_t mem_inst [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic push;
	logic pop;

	assign in.ready = (count != (PTR_W+1)'(DEPTH));
	assign out.valid = (count != '0);
	assign push = in.valid && in.ready;
	assign pop = out.valid && out.ready;

	assign out.warp = mem_warp[rd_ptr];
	assign out.pc = mem_pc[rd_ptr];
	assign out.inst = mem_inst[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem_warp[wr_ptr] <= in.warp;
			mem_pc[wr_ptr] <= in.pc;
			mem_inst[wr_ptr] <= in.inst;
		end
	end

	assert property (@(posedge clk) disable iff (rst) count <= (PTR_W+1)'(DEPTH))
		else $error("fetch queue count %0d over depth", count);

endmodule

// File: hdl/front_params.svh
`ifndef FRONT_PARAMS_SVH
`define FRONT_PARAMS_SVH

// Hardware warp contexts in the front end
`define NUM_WARPS 8

// Fetched instructions buffered between scheduler and decoder
`define FQ_DEPTH 4

// PC held by a warp that is not running
`define PC_RESET 32'h0000_0000

`endif

// File: hdl/inst_decode.sv
`timescale 1ns/1ns

module inst_decode (
	input  logic clk,
	input  logic rst,
	fetch_if.dst in,
	pc_update_if.src upd,
	output logic dec_valid,
	input  logic dec_ready,
	output warp_pkg::warp_id_t dec_warp,
	output warp_pkg::pc_t dec_pc,
	output isa_pkg::opcode_t dec_opcode,
	output isa_pkg::reg_idx_t dec_dst,
	output isa_pkg::reg_idx_t dec_src1,
	output isa_pkg::reg_idx_t dec_src2,
	output isa_pkg::imm_t dec_imm,
	output logic dec_reg_write,
	output logic dec_mem_read,
	output logic dec_mem_write,
	output logic dec_src1_valid,
	output logic dec_src2_valid,
	output logic dec_imm_valid,
	output logic dec_jmp,
	output logic dec_beq,
	output logic dec_blt,
	output logic dec_exit
);

	isa_pkg::opcode_t op;
	logic reg_write, mem_read, mem_write;
	logic src1_v, src2_v, imm_v;
	logic jmp, beq, blt, ex;
	logic take;
	logic retire;
	warp_pkg::pc_t next_pc;

	assign in.ready = !dec_valid || dec_ready;
	assign take = in.valid && in.ready;
	assign retire = dec_valid && dec_ready;

	always_comb begin
		op = isa_pkg::opcode_t'(in.inst[31:28]);
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		src1_v = 1'b0;
		src2_v = 1'b0;
		imm_v = 1'b0;
		jmp = 1'b0;
		beq = 1'b0;
		blt = 1'b0;
		ex = 1'b0;
		case (op)
			isa_pkg::OP_ADD, isa_pkg::OP_SUB: begin
				reg_write = 1'b1;
				src1_v = 1'b1;
				src2_v = 1'b1;
			end
			isa_pkg::OP_ADDI, isa_pkg::OP_LD: begin
				reg_write = 1'b1;
				src1_v = 1'b1;
				imm_v = 1'b1;
				mem_read = (op == isa_pkg::OP_LD);
			end
			isa_pkg::OP_ST: begin
				mem_write = 1'b1;
				src1_v = 1'b1;
				src2_v = 1'b1;
				imm_v = 1'b1;
			end
			isa_pkg::OP_JMP: jmp = 1'b1;
			isa_pkg::OP_BEQ, isa_pkg::OP_BLT: begin  // flagged only, falls through
				beq = (op == isa_pkg::OP_BEQ);
				blt = (op == isa_pkg::OP_BLT);
				src1_v = 1'b1;
				src2_v = 1'b1;
				imm_v = 1'b1;
			end
			isa_pkg::OP_EXIT: ex = 1'b1;
			default: ;  // no-op
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			dec_valid <= 1'b0;
		else if (take)
			dec_valid <= 1'b1;
		else if (dec_ready)
			dec_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			dec_warp <= in.warp;
			dec_pc <= in.pc;
			dec_opcode <= op;
			dec_dst <= in.inst[27:23];
			dec_src1 <= in.inst[22:18];
			dec_src2 <= in.inst[17:13];
			dec_imm <= in.inst[15:0];
			dec_reg_write <= reg_write;
			dec_mem_read <= mem_read;
			dec_mem_write <= mem_write;
			dec_src1_valid <= src1_v;
			dec_src2_valid <= src2_v;
			dec_imm_valid <= imm_v;
			dec_jmp <= jmp;
			dec_beq <= beq;
			dec_blt <= blt;
			dec_exit <= ex;
		end
	end

	// Word-index jump target
	assign next_pc = dec_jmp ? warp_pkg::pc_t'({dec_imm, 2'b00}) : dec_pc + 32'd4;

	always_ff @(posedge clk) begin
		if (rst)
			upd.valid <= 1'b0;
		else
			upd.valid <= retire;
	end

	always_ff @(posedge clk) begin
		if (retire) begin
			upd.warp <= dec_warp;
			upd.next_pc <= next_pc;
			upd.keep_active <= !dec_exit;
		end
	end

	// Held instruction must not change under back-pressure
	assert property (@(posedge clk) disable iff (rst)
		dec_valid && !dec_ready |=> dec_valid && $stable({dec_warp, dec_pc, dec_opcode,
			dec_dst, dec_src1, dec_src2, dec_imm, dec_reg_write, dec_mem_read,
			dec_mem_write, dec_src1_valid, dec_src2_valid, dec_imm_valid,
			dec_jmp, dec_beq, dec_blt, dec_exit}))
		else $error("decoded output changed while stalled");

endmodule

// File: hdl/isa_pkg.sv
package isa_pkg;

	// Word layout
	//   31:28 opcode
	//   27:23 dst
	//   22:18 src1
	//   17:13 src2
	//   15:0  immediate, overlaps src2
	typedef logic [31:0] inst_t;

	typedef logic [4:0] reg_idx_t;

	typedef logic [15:0] imm_t;

	// Codes not listed decode as a no-op
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_ADDI = 4'd2,
		OP_LD   = 4'd3,
		OP_ST   = 4'd4,
		OP_JMP  = 4'd5,
		OP_BEQ  = 4'd6,
		OP_BLT  = 4'd7,
		OP_EXIT = 4'd15
	} opcode_t;

endpackage

// File: hdl/warp_fetch.sv
`timescale 1ns/1ns

`include "front_params.svh"

module warp_fetch (
	input  logic clk,
	input  logic rst,
	input  logic warp_start,
	input  warp_pkg::warp_id_t start_warp,
	input  warp_pkg::pc_t start_pc,
	output warp_pkg::pc_t imem_addr,
	input  isa_pkg::inst_t imem_data,
	fetch_if.src fetch,
	pc_update_if.dst upd
);

	warp_pkg::sched_state_t state [`NUM_WARPS];
	warp_pkg::pc_t pc_tab [`NUM_WARPS];

	warp_pkg::warp_mask_t ready_mask;
	warp_pkg::warp_id_t last_grant;  // search starts just after this one
	warp_pkg::warp_id_t cand;
	warp_pkg::warp_id_t grant_id;
	logic grant_valid;
	logic issue;

	always_comb begin
		for (int i = 0; i < `NUM_WARPS; i++) begin
			ready_mask[i] = (state[i] == warp_pkg::READY);
		end
	end

	// Rotating priority with the last grant itself tried last
	always_comb begin
		grant_valid = 1'b0;
		grant_id = last_grant;
		cand = last_grant;
		for (int i = 1; i <= `NUM_WARPS; i++) begin
			cand = last_grant + warp_pkg::warp_id_t'(i);
			if (!grant_valid && ready_mask[cand]) begin
				grant_valid = 1'b1;
				grant_id = cand;
			end
		end
	end

	// Output slot free or draining this cycle
	assign issue = grant_valid && (!fetch.valid || fetch.ready);

	assign imem_addr = pc_tab[grant_id];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NUM_WARPS; i++) begin
				state[i] <= warp_pkg::IDLE;
				pc_tab[i] <= `PC_RESET;
			end
			last_grant <= '0;
			fetch.valid <= 1'b0;
		end else begin
			if (issue) begin
				state[grant_id] <= warp_pkg::IN_FLIGHT;
				last_grant <= grant_id;
				fetch.valid <= 1'b1;
			end else if (fetch.ready) begin
				fetch.valid <= 1'b0;
			end

			// Returning warp is IN_FLIGHT, so never the one granted above
			if (upd.valid) begin
				state[upd.warp] <= upd.keep_active ? warp_pkg::READY : warp_pkg::IDLE;
				pc_tab[upd.warp] <= upd.keep_active ? upd.next_pc : `PC_RESET;
			end

			if (warp_start && state[start_warp] == warp_pkg::IDLE) begin
				state[start_warp] <= warp_pkg::READY;
				pc_tab[start_warp] <= start_pc;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			fetch.warp <= grant_id;
			fetch.pc <= pc_tab[grant_id];
			fetch.inst <= imem_data;
		end
	end

	// Launching a running warp is a host error and gets dropped
	assert property (@(posedge clk) disable iff (rst)
		warp_start |-> state[start_warp] == warp_pkg::IDLE)
		else $error("warp_start for busy warp %0d", start_warp);

	// Granted warp is READY with nothing left in the slot or coming back
	assert property (@(posedge clk) disable iff (rst)
		issue |-> state[grant_id] == warp_pkg::READY
			&& !(fetch.valid && fetch.warp == grant_id)
			&& !(upd.valid && upd.warp == grant_id))
		else $error("grant to warp %0d that was not READY", grant_id);

endmodule

// File: hdl/warp_pkg.sv
`include "front_params.svh"

package warp_pkg;

	// Index of one hardware warp
	typedef logic [$clog2(`NUM_WARPS)-1:0] warp_id_t;

	// One bit per warp
	typedef logic [`NUM_WARPS-1:0] warp_mask_t;

	// Byte address, low two bits always zero
	typedef logic [31:0] pc_t;

	// Per-warp scheduling state
	typedef enum logic [1:0] {
		IDLE,      // not started or exited
		READY,     // waiting for a fetch slot
		IN_FLIGHT  // one instruction somewhere between fetch and decode
	} sched_state_t;

endpackage

// File: list.f
+incdir+hdl
hdl/warp_pkg.sv
hdl/isa_pkg.sv
hdl/fetch_if.sv
hdl/warp_fetch.sv
hdl/fetch_queue.sv
hdl/inst_decode.sv
hdl/fetch_decode.sv
testbench/tb_fetch_decode.sv

// File: testbench/tb_fetch_decode.sv
`timescale 1ns/1ns

`include "front_params.svh"

module tb_fetch_decode;

	localparam int NUM_TESTS = 6;
	localparam int MAX_TRACE = 64;
	localparam int QUIET_CYCLES = 20;
	localparam logic [3:0] GEN_OPS [9] = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd6, 4'd7, 4'd9, 4'd12};

	logic clk;
	logic rst;
	logic warp_start;
	warp_pkg::warp_id_t start_warp;
	warp_pkg::pc_t start_pc;
	warp_pkg::pc_t imem_addr;
	isa_pkg::inst_t imem_data;
	logic dec_valid;
	logic dec_ready;
	warp_pkg::warp_id_t dec_warp;
	warp_pkg::pc_t dec_pc;
	isa_pkg::opcode_t dec_opcode;
	isa_pkg::reg_idx_t dec_dst;
	isa_pkg::reg_idx_t dec_src1;
	isa_pkg::reg_idx_t dec_src2;
	isa_pkg::imm_t dec_imm;
	logic dec_reg_write;
	logic dec_mem_read;
	logic dec_mem_write;
	logic dec_src1_valid;
	logic dec_src2_valid;
	logic dec_imm_valid;
	logic dec_jmp;
	logic dec_beq;
	logic dec_blt;
	logic dec_exit;

	logic [31:0] imem [0:1023];

	string test_name [NUM_TESTS];
	warp_pkg::warp_mask_t test_warps [NUM_TESTS];
	warp_pkg::pc_t test_pc [NUM_TESTS][`NUM_WARPS];
	bit test_rand_ready [NUM_TESTS];

	warp_pkg::warp_mask_t cur_warps;
	warp_pkg::pc_t exp_pc [`NUM_WARPS][MAX_TRACE];  // expected PC trace per warp
	int exp_len [`NUM_WARPS];
	int got_cnt [`NUM_WARPS];

	logic [31:0] lcg_state = 32'h8c7f;
	int budget_cycles = 0;
	int total_errors = 0;
	int tests_failed = 0;

	fetch_decode i_dut (.*);

	assign imem_data = imem[imem_addr[11:2]];  // combinational read

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] r_type(logic [3:0] op, logic [4:0] d, logic [4:0] a,
			logic [4:0] b);
		return {op, d, a, b, 13'h0};
	endfunction

	function automatic logic [31:0] i_type(logic [3:0] op, logic [4:0] d, logic [4:0] a,
			logic [15:0] imm);
		return {op, d, a, 2'b00, imm};
	endfunction

	function automatic logic [31:0] gen_inst(int w, int k);
		return {GEN_OPS[(w + k) % 9], 5'(w * 3 + k), 5'(k + 1), 5'(w), 13'(w * 37 + k * 5)};
	endfunction

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// reg_write mem_read mem_write src1 src2 imm jmp beq blt exit
	function automatic logic [9:0] exp_flags(logic [3:0] op);
		case (op)
			4'd0, 4'd1: return 10'b1_0_0_1_1_0_0_0_0_0;
			4'd2: return 10'b1_0_0_1_0_1_0_0_0_0;
			4'd3: return 10'b1_1_0_1_0_1_0_0_0_0;
			4'd4: return 10'b0_0_1_1_1_1_0_0_0_0;
			4'd5: return 10'b0_0_0_0_0_0_1_0_0_0;
			4'd6: return 10'b0_0_0_1_1_1_0_1_0_0;
			4'd7: return 10'b0_0_0_1_1_1_0_0_1_0;
			4'd15: return 10'b0_0_0_0_0_0_0_0_0_1;
			default: return 10'b0;
		endcase
	endfunction

	function automatic string flag_name(int i);
		case (i)
			9: return "dec_reg_write";
			8: return "dec_mem_read";
			7: return "dec_mem_write";
			6: return "dec_src1_valid";
			5: return "dec_src2_valid";
			4: return "dec_imm_valid";
			3: return "dec_jmp";
			2: return "dec_beq";
			1: return "dec_blt";
			default: return "dec_exit";
		endcase
	endfunction

	function automatic logic [79:0] out_bits();
		return {dec_warp, dec_pc, 4'(dec_opcode), dec_dst, dec_src1, dec_src2, dec_imm,
			dec_reg_write, dec_mem_read, dec_mem_write, dec_src1_valid, dec_src2_valid,
			dec_imm_valid, dec_jmp, dec_beq, dec_blt, dec_exit};
	endfunction

	function automatic bit all_done();
		for (int w = 0; w < `NUM_WARPS; w++)
			if (got_cnt[w] != exp_len[w])
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic report_error(string msg);
		$display("ERROR %s", msg);
		total_errors++;
	endtask

	task automatic check_value(string sig, logic [31:0] got, logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAIL %s got %h expected %h (warp %0d, pc %h)", sig, got, exp,
				dec_warp, dec_pc);
			total_errors++;
		end
	endtask

	task automatic load_memory();
		int base;
		int len;
		for (int i = 0; i < 1024; i++)
			imem[i] = {4'hF, 16'h0, 12'(i * 4)};  // EXIT tagged with its own address
		// Warp 0 straight line at 0x000
		imem['h000 / 4] = r_type(4'd0, 5'd1, 5'd2, 5'd3);
		imem['h004 / 4] = r_type(4'd1, 5'd4, 5'd1, 5'd5);
		imem['h008 / 4] = i_type(4'd2, 5'd6, 5'd4, 16'h1234);
		imem['h00C / 4] = i_type(4'd3, 5'd7, 5'd6, 16'h0010);
		imem['h010 / 4] = i_type(4'd4, 5'd8, 5'd6, 16'h6020);
		imem['h014 / 4] = r_type(4'hF, 5'd0, 5'd0, 5'd0);
		// Warp 0 restart target
		imem['h040 / 4] = i_type(4'd3, 5'd12, 5'd13, 16'h0FF0);
		imem['h044 / 4] = r_type(4'd7, 5'd0, 5'd14, 5'd15);
		imem['h048 / 4] = r_type(4'd9, 5'd16, 5'd17, 5'd18);
		imem['h04C / 4] = r_type(4'hF, 5'd0, 5'd0, 5'd0);
		// Warp 1 branches and jumps
		imem['h100 / 4] = r_type(4'd6, 5'd0, 5'd2, 5'd3);
		imem['h104 / 4] = r_type(4'd7, 5'd0, 5'd4, 5'd5);
		imem['h108 / 4] = i_type(4'd5, 5'd0, 5'd0, 16'h0048);  // to 0x120
		imem['h10C / 4] = r_type(4'd0, 5'd9, 5'd9, 5'd9);  // skipped
		imem['h120 / 4] = i_type(4'd2, 5'd10, 5'd11, 16'hBEEF);
		imem['h124 / 4] = i_type(4'd5, 5'd0, 5'd0, 16'h004C);  // to 0x130
		imem['h130 / 4] = r_type(4'hF, 5'd0, 5'd0, 5'd0);
		// Generated body at base + 0x80, then JMP to an EXIT at base + 0xE0
		for (int w = 0; w < `NUM_WARPS; w++) begin
			base = w * 'h100;
			len = 3 + w;
			for (int k = 0; k < len; k++)
				imem[(base + 'h80) / 4 + k] = gen_inst(w, k);
			imem[(base + 'h80) / 4 + len] = i_type(4'd5, 5'd0, 5'd0, 16'((base + 'hE0) / 4));
			imem[(base + 'hE0) / 4] = r_type(4'hF, 5'(w), 5'd0, 5'd0);
		end
	endtask

	task automatic build_table();
		for (int t = 0; t < NUM_TESTS; t++) begin
			test_warps[t] = '0;
			test_rand_ready[t] = 1'b0;
			for (int w = 0; w < `NUM_WARPS; w++)
				test_pc[t][w] = 32'(w * 'h100 + 'h80);
		end
		test_name[0] = "reset";
		test_name[1] = "straight_line";
		test_warps[1] = 8'h01;
		test_pc[1][0] = 32'h000;
		test_name[2] = "jump_branch";
		test_warps[2] = 8'h02;
		test_pc[2][1] = 32'h100;
		test_name[3] = "all_warps";
		test_warps[3] = 8'hFF;
		test_name[4] = "back_pressure";
		test_warps[4] = 8'hAA;
		test_rand_ready[4] = 1'b1;
		test_name[5] = "restart";
		test_warps[5] = 8'h01;
		test_pc[5][0] = 32'h040;  // warp 0 has exited before
	endtask

	// Walks the program by the next-PC rules up to its EXIT
	task automatic build_trace(int w, warp_pkg::pc_t start);
		warp_pkg::pc_t pc;
		logic [31:0] inst;
		bit done;
		pc = start;
		done = 1'b0;
		exp_len[w] = 0;
		while (!done && exp_len[w] < MAX_TRACE) begin
			inst = imem[pc[11:2]];
			exp_pc[w][exp_len[w]] = pc;
			exp_len[w]++;
			if (inst[31:28] == 4'hF)
				done = 1'b1;
			else if (inst[31:28] == 4'd5)
				pc = {14'h0, inst[15:0], 2'b00};
			else
				pc = pc + 32'd4;
		end
		assert (done) else report_error($sformatf("program of warp %0d at %h has no EXIT", w, start));
	endtask

	task automatic compute_budget();
		int sum;
		int n;
		int total;
		total = 10;
		for (int t = 0; t < NUM_TESTS; t++) begin
			sum = 0;
			n = 0;
			for (int w = 0; w < `NUM_WARPS; w++) begin
				if (test_warps[t][w]) begin
					build_trace(w, test_pc[t][w]);
					sum += exp_len[w];
					n++;
				end
			end
			total += sum * n * 20 + 60;
		end
		budget_cycles = total;
	endtask

	task automatic check_output();
		int w;
		int n;
		bit ok;
		logic [31:0] inst;
		logic [9:0] got_f;
		logic [9:0] exp_f;
		w = int'(dec_warp);
		n = got_cnt[w];
		ok = cur_warps[w] && n < exp_len[w];
		assert (ok) else report_error($sformatf(
			"warp %0d delivered an instruction at %h that was not expected", w, dec_pc));
		if (ok) begin
			inst = imem[exp_pc[w][n][11:2]];
			check_value("dec_pc", dec_pc, exp_pc[w][n]);
			check_value("dec_opcode", 32'(dec_opcode), 32'(inst[31:28]));
			check_value("dec_dst", 32'(dec_dst), 32'(inst[27:23]));
			check_value("dec_src1", 32'(dec_src1), 32'(inst[22:18]));
			check_value("dec_src2", 32'(dec_src2), 32'(inst[17:13]));
			check_value("dec_imm", 32'(dec_imm), 32'(inst[15:0]));
			got_f = {dec_reg_write, dec_mem_read, dec_mem_write, dec_src1_valid,
				dec_src2_valid, dec_imm_valid, dec_jmp, dec_beq, dec_blt, dec_exit};
			exp_f = exp_flags(inst[31:28]);
			for (int i = 0; i < 10; i++)
				check_value(flag_name(i), 32'(got_f[i]), 32'(exp_f[i]));
			got_cnt[w]++;
		end
	endtask

	task automatic run_test(int t);
		int next_w;
		int quiet;
		int errs_before;
		int n_inst;
		bit held;
		bit was_done;
		logic [79:0] held_bits;
		errs_before = total_errors;
		cur_warps = test_warps[t];
		n_inst = 0;
		for (int w = 0; w < `NUM_WARPS; w++) begin
			got_cnt[w] = 0;
			exp_len[w] = 0;
			if (cur_warps[w])
				build_trace(w, test_pc[t][w]);
			n_inst += exp_len[w];
		end
		next_w = 0;
		quiet = 0;
		held = 1'b0;
		while (quiet < QUIET_CYCLES) begin
			@(posedge clk);
			#1;
			while (next_w < `NUM_WARPS && !cur_warps[next_w])
				next_w++;
			warp_start = (next_w < `NUM_WARPS);  // one launch per cycle
			if (warp_start) begin
				start_warp = warp_pkg::warp_id_t'(next_w);
				start_pc = test_pc[t][next_w];
				next_w++;
			end
			if (test_rand_ready[t]) begin
				lcg_state = lcg_next(lcg_state);
				dec_ready = lcg_state[16];
			end else begin
				dec_ready = 1'b1;
			end
			@(negedge clk);
			if (held) begin
				assert (dec_valid) else report_error("dec_valid dropped while dec_ready was low");
				assert (out_bits() === held_bits) else begin
					$display("FAIL dec outputs got %h expected %h", out_bits(), held_bits);
					total_errors++;
				end
			end
			held = dec_valid && !dec_ready;
			held_bits = out_bits();
			was_done = all_done();
			if (dec_valid && dec_ready)
				check_output();
			if (was_done) begin
				check_value("dec_valid", 32'(dec_valid), 32'd0);
				quiet++;
			end
		end
		if (total_errors == errs_before) begin
			$display("[%s] passed, %0d instructions", test_name[t], n_inst);
		end else begin
			$display("[%s] failed with %0d errors", test_name[t], total_errors - errs_before);
			tests_failed++;
		end
	endtask

	initial begin
		rst = 1'b1;
		warp_start = 1'b0;
		start_warp = '0;
		start_pc = '0;
		dec_ready = 1'b0;
		load_memory();
		build_table();
		compute_budget();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS,
			NUM_TESTS - tests_failed, tests_failed, total_errors);
		if (total_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin
		wait (budget_cycles > 0);
		repeat (budget_cycles) @(posedge clk);
		$display("ERROR run did not finish within %0d cycles", budget_cycles);
		$display("Test FAILED");
		$finish;
	end

endmodule
